// ==== rtl/fifo_ctl_pkg.sv ====
// Shared sizes, types and flag structs for the single clock FIFO controller
// ADDR_W sets the depth and the storage array must hold DEPTH_WORDS entries
`default_nettype none

package fifo_ctl_pkg;

	// Storage address bits. The pointers carry one extra wrap bit on top
	localparam int ADDR_W = 4;
	localparam int DEPTH_WORDS = 1 << ADDR_W;
	localparam int PTR_W = ADDR_W + 1;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [PTR_W-1:0] ptr_t;

	// Entry count from 0 up to DEPTH_WORDS inclusive, so it needs PTR_W bits
	typedef logic [PTR_W-1:0] level_t;

	localparam level_t DEPTH_LVL = level_t'(DEPTH_WORDS);

	typedef struct packed {
		level_t almost_full_lvl;
		level_t almost_empty_lvl;
	} fifo_thresh_t;

	typedef struct packed {
		logic full;
		logic full_minus_one;
		logic almost_full;
		logic overflow;
	} push_flags_t;

	typedef struct packed {
		logic empty;
		logic empty_plus_one;
		logic almost_empty;
		logic underflow;
	} pop_flags_t;

	// An empty FIFO shows empty and almost empty out of reset
	localparam push_flags_t PUSH_FLAGS_RST = '0;
	localparam pop_flags_t POP_FLAGS_RST = '{
		empty: 1'b1,
		empty_plus_one: 1'b0,
		almost_empty: 1'b1,
		underflow: 1'b0
	};

	// The wrap bit makes the plain difference correct across wraparound
	function automatic level_t occupancy(ptr_t wr, ptr_t rd);
		return level_t'(wr - rd);
	endfunction

	function automatic level_t free_count(ptr_t wr, ptr_t rd);
		return DEPTH_LVL - occupancy(wr, rd);
	endfunction

endpackage

`default_nettype wire

// ==== rtl/fifo_push_ctl.sv ====
// Push side of the FIFO controller. Flags are registered and see the read
// pointer one cycle late, so a pop frees space on the push side a cycle after
// it happens. A push while full only sets overflow
`timescale 1ns/1ps
`default_nettype none

module fifo_push_ctl (
	input  wire                        rclk,
	input  wire                        rst_n,
	input  wire                        wen,
	input  wire fifo_ctl_pkg::ptr_t    rptr,
	input  wire fifo_ctl_pkg::fifo_thresh_t thresh,
	output fifo_ctl_pkg::ptr_t         wptr,
	output fifo_ctl_pkg::push_flags_t  flags
);

	fifo_ctl_pkg::ptr_t wptr_q;
	fifo_ctl_pkg::ptr_t wptr_next;
	fifo_ctl_pkg::level_t free_next;
	fifo_ctl_pkg::push_flags_t flags_q;
	fifo_ctl_pkg::push_flags_t flags_next;
	logic push_ok;
	logic overflow_next;

	// Only the full flag gates a push
	assign push_ok = wen & ~flags_q.full;

	always_comb begin
		if (push_ok) begin
			wptr_next = wptr_q + fifo_ctl_pkg::ptr_t'(1);
		end else begin
			wptr_next = wptr_q;
		end
	end

	// Free space as it will be after this edge, with the pop side credited late
	assign free_next = fifo_ctl_pkg::free_count(wptr_next, rptr);

	// Overflow follows every push request and holds between requests
	always_comb begin
		if (wen) begin
			overflow_next = flags_q.full;
		end else begin
			overflow_next = flags_q.overflow;
		end
	end

	always_comb begin
		flags_next.full = (free_next == '0);
		flags_next.full_minus_one = (free_next == fifo_ctl_pkg::level_t'(1));
		// Strict compare, so a threshold of 0 never raises almost full
		flags_next.almost_full = (free_next < thresh.almost_full_lvl);
		flags_next.overflow = overflow_next;
	end

	always_ff @(posedge rclk or negedge rst_n) begin
		if (!rst_n) begin
			wptr_q <= '0;
		end else begin
			wptr_q <= wptr_next;
		end
	end

	always_ff @(posedge rclk or negedge rst_n) begin
		if (!rst_n) begin
			flags_q <= fifo_ctl_pkg::PUSH_FLAGS_RST;
		end else begin
			flags_q <= flags_next;
		end
	end

	assign wptr = wptr_q;
	assign flags = flags_q;

endmodule

`default_nettype wire

// ==== rtl/fifo_pop_ctl.sv ====
// Pop side of the FIFO controller. Flags are registered and see the write
// pointer one cycle late, so a push becomes visible here a cycle after its
// edge. A pop while empty only sets underflow
`timescale 1ns/1ps
`default_nettype none

module fifo_pop_ctl (
	input  wire                        rclk,
	input  wire                        rst_n,
	input  wire                        ren,
	input  wire fifo_ctl_pkg::ptr_t    wptr,
	input  wire fifo_ctl_pkg::fifo_thresh_t thresh,
	output fifo_ctl_pkg::ptr_t         rptr,
	output fifo_ctl_pkg::pop_flags_t   flags
);

	fifo_ctl_pkg::ptr_t rptr_q;
	fifo_ctl_pkg::ptr_t rptr_next;
	fifo_ctl_pkg::level_t used_next;
	fifo_ctl_pkg::pop_flags_t flags_q;
	fifo_ctl_pkg::pop_flags_t flags_next;
	logic pop_ok;
	logic underflow_next;

	// Only the empty flag gates a pop
	assign pop_ok = ren & ~flags_q.empty;

	always_comb begin
		if (pop_ok) begin
			rptr_next = rptr_q + fifo_ctl_pkg::ptr_t'(1);
		end else begin
			rptr_next = rptr_q;
		end
	end

	// Entries held after this edge, counting only pushes already registered
	assign used_next = fifo_ctl_pkg::occupancy(wptr, rptr_next);

	// Underflow follows every pop request and holds between requests
	always_comb begin
		if (ren) begin
			underflow_next = flags_q.empty;
		end else begin
			underflow_next = flags_q.underflow;
		end
	end

	always_comb begin
		flags_next.empty = (used_next == '0);
		flags_next.empty_plus_one = (used_next == fifo_ctl_pkg::level_t'(1));
		// A threshold of DEPTH_WORDS keeps almost empty high until full
		flags_next.almost_empty = (used_next < thresh.almost_empty_lvl);
		flags_next.underflow = underflow_next;
	end

	always_ff @(posedge rclk or negedge rst_n) begin
		if (!rst_n) begin
			rptr_q <= '0;
		end else begin
			rptr_q <= rptr_next;
		end
	end

	always_ff @(posedge rclk or negedge rst_n) begin
		if (!rst_n) begin
			flags_q <= fifo_ctl_pkg::POP_FLAGS_RST;
		end else begin
			flags_q <= flags_next;
		end
	end

	assign rptr = rptr_q;
	assign flags = flags_q;

endmodule

`default_nettype wire

// ==== rtl/fifo_ctl.sv ====
// Single clock FIFO controller. The storage array is external and is written
// at waddr when wen is high and full is low, and read at raddr likewise
// Thresholds must stay stable while the FIFO is in use
`timescale 1ns/1ps
`default_nettype none

module fifo_ctl (
	input  wire                        rclk,
	input  wire                        rst_n,
	input  wire                        wen,
	input  wire                        ren,
	input  wire fifo_ctl_pkg::fifo_thresh_t thresh,
	output fifo_ctl_pkg::addr_t        waddr,
	output fifo_ctl_pkg::addr_t        raddr,
	output fifo_ctl_pkg::push_flags_t  push_flags,
	output fifo_ctl_pkg::pop_flags_t   pop_flags
);

	fifo_ctl_pkg::ptr_t wptr;
	fifo_ctl_pkg::ptr_t rptr;

	// Each side gets the other side's registered pointer directly
	fifo_push_ctl push_i (
		.rclk   (rclk),
		.rst_n  (rst_n),
		.wen    (wen),
		.rptr   (rptr),
		.thresh (thresh),
		.wptr   (wptr),
		.flags  (push_flags)
	);

	fifo_pop_ctl pop_i (
		.rclk   (rclk),
		.rst_n  (rst_n),
		.ren    (ren),
		.wptr   (wptr),
		.thresh (thresh),
		.rptr   (rptr),
		.flags  (pop_flags)
	);

	// Drop the wrap bit to address the storage array
	assign waddr = wptr[fifo_ctl_pkg::ADDR_W-1:0];
	assign raddr = rptr[fifo_ctl_pkg::ADDR_W-1:0];

endmodule

`default_nettype wire

// ==== tests/fifo_ctl_asserts.sv ====
// Pointer and flag rules of fifo_ctl, bound into every fifo_ctl instance
// All checks are off while rst_n is low
`timescale 1ns/1ps
`default_nettype none

module fifo_ctl_asserts (
	input wire                              rclk,
	input wire                              rst_n,
	input wire                              wen,
	input wire                              ren,
	input wire fifo_ctl_pkg::ptr_t          wptr,
	input wire fifo_ctl_pkg::ptr_t          rptr,
	input wire fifo_ctl_pkg::push_flags_t   push_flags,
	input wire fifo_ctl_pkg::pop_flags_t    pop_flags
);

	int unsigned fail_count = 0;

	full_not_empty: assert property (@(posedge rclk) disable iff (!rst_n)
		!(push_flags.full && pop_flags.empty))
		else begin
			fail_count++;
			$error("full and empty are high together");
		end

	// A refused request leaves its pointer where it was
	wptr_held: assert property (@(posedge rclk) disable iff (!rst_n)
		wen && push_flags.full |=> $stable(wptr))
		else begin
			fail_count++;
			$error("wptr moved on a push while full");
		end

	rptr_held: assert property (@(posedge rclk) disable iff (!rst_n)
		ren && pop_flags.empty |=> $stable(rptr))
		else begin
			fail_count++;
			$error("rptr moved on a pop while empty");
		end

	// The read pointer never overtakes the write pointer it could see
	ptr_distance: assert property (@(posedge rclk) disable iff (!rst_n)
		1'b1 |=> fifo_ctl_pkg::level_t'($past(wptr) - rptr) <= fifo_ctl_pkg::DEPTH_LVL)
		else begin
			fail_count++;
			$error("pointer distance exceeds the FIFO depth");
		end

endmodule

bind fifo_ctl fifo_ctl_asserts asserts_i (
	.rclk       (rclk),
	.rst_n      (rst_n),
	.wen        (wen),
	.ren        (ren),
	.wptr       (wptr),
	.rptr       (rptr),
	.push_flags (push_flags),
	.pop_flags  (pop_flags)
);

`default_nettype wire

// ==== tests/fifo_ctl_tb.sv ====
// Testbench for fifo_ctl. A cycle model of the pointer and flag rules runs beside the DUT
// Inputs change 1 ns after the rising edge and outputs are compared on the falling edge
`timescale 1ns/1ps
`default_nettype none

module fifo_ctl_tb;

	localparam int DEPTH = fifo_ctl_pkg::DEPTH_WORDS;
	localparam int RST_CYCLES = 8;
	localparam int N_RANDOM = 400;
	localparam int STIM_CYCLES = RST_CYCLES + 2 * (DEPTH + 3) + 3 + 2 * (2 * DEPTH + 3)
		+ N_RANDOM + 2;
	localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES + 100;
	localparam int unsigned SEED = 32'ha1c1_895a;

	typedef struct packed {
		fifo_ctl_pkg::ptr_t wptr;
		fifo_ctl_pkg::ptr_t rptr;
		fifo_ctl_pkg::push_flags_t push_flags;
		fifo_ctl_pkg::pop_flags_t pop_flags;
	} model_t;

	logic rclk;
	logic rst_n;
	logic wen;
	logic ren;
	fifo_ctl_pkg::fifo_thresh_t thresh;
	fifo_ctl_pkg::addr_t waddr;
	fifo_ctl_pkg::addr_t raddr;
	fifo_ctl_pkg::push_flags_t push_flags;
	fifo_ctl_pkg::pop_flags_t pop_flags;
	model_t model;
	int cycle_count;

	fifo_ctl dut_i (
		.rclk       (rclk),
		.rst_n      (rst_n),
		.wen        (wen),
		.ren        (ren),
		.thresh     (thresh),
		.waddr      (waddr),
		.raddr      (raddr),
		.push_flags (push_flags),
		.pop_flags  (pop_flags)
	);

	initial begin
		rclk = 1'b0;
		forever #4 rclk = ~rclk;
	end

	function automatic model_t reset_state();
		model_t st;
		st = '0;
		st.pop_flags.empty = 1'b1;
		st.pop_flags.almost_empty = 1'b1;
		return st;
	endfunction

	// Push flags see the new write pointer against the old read pointer, and pop flags the reverse
	function automatic model_t next_state(model_t cur, logic w, logic r,
		fifo_ctl_pkg::fifo_thresh_t th);
		model_t nxt;
		int free_words;
		int used_words;
		nxt = cur;
		if (w && !cur.push_flags.full) begin
			nxt.wptr = cur.wptr + 1'b1;
		end
		if (r && !cur.pop_flags.empty) begin
			nxt.rptr = cur.rptr + 1'b1;
		end
		free_words = DEPTH - ((int'(nxt.wptr) - int'(cur.rptr) + 2 * DEPTH) % (2 * DEPTH));
		used_words = (int'(cur.wptr) - int'(nxt.rptr) + 2 * DEPTH) % (2 * DEPTH);
		nxt.push_flags.full = (free_words == 0);
		nxt.push_flags.full_minus_one = (free_words == 1);
		nxt.push_flags.almost_full = (free_words < int'(th.almost_full_lvl));
		nxt.push_flags.overflow = w ? cur.push_flags.full : cur.push_flags.overflow;
		nxt.pop_flags.empty = (used_words == 0);
		nxt.pop_flags.empty_plus_one = (used_words == 1);
		nxt.pop_flags.almost_empty = (used_words < int'(th.almost_empty_lvl));
		nxt.pop_flags.underflow = r ? cur.pop_flags.empty : cur.pop_flags.underflow;
		return nxt;
	endfunction

	function automatic fifo_ctl_pkg::fifo_thresh_t make_thresh(int af, int ae);
		fifo_ctl_pkg::fifo_thresh_t th;
		th.almost_full_lvl = fifo_ctl_pkg::level_t'(af);
		th.almost_empty_lvl = fifo_ctl_pkg::level_t'(ae);
		return th;
	endfunction

	task automatic report_failure();
		$display("ERRORS FOUND");
		$fatal(1, "Run stopped at the first failure");
	endtask

	task automatic check_addr(string name, fifo_ctl_pkg::addr_t got, fifo_ctl_pkg::addr_t exp);
		if (got !== exp) begin
			$display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
			report_failure();
		end
	endtask

	task automatic check_push(fifo_ctl_pkg::push_flags_t got, fifo_ctl_pkg::push_flags_t exp);
		if (got !== exp) begin
			$display("MISMATCH push_flags got 0x%h expected 0x%h", got, exp);
			report_failure();
		end
	endtask

	task automatic check_pop(fifo_ctl_pkg::pop_flags_t got, fifo_ctl_pkg::pop_flags_t exp);
		if (got !== exp) begin
			$display("MISMATCH pop_flags got 0x%h expected 0x%h", got, exp);
			report_failure();
		end
	endtask

	task automatic expect_true(logic cond, string what);
		if (!cond) begin
			$display("Directed phase went wrong: %s", what);
			report_failure();
		end
	endtask

	task automatic run_cycles(logic w, logic r, int n);
		repeat (n) begin
			@(posedge rclk);
			#1;
			wen = w;
			ren = r;
		end
	endtask

	// Model steps on the rising edge and the DUT is compared half a cycle later
	initial begin
		model = reset_state();
		forever begin
			@(posedge rclk);
			if (!rst_n) begin
				model = reset_state();
			end else begin
				model = next_state(model, wen, ren, thresh);
			end
			@(negedge rclk);
			check_addr("waddr", waddr, model.wptr[fifo_ctl_pkg::ADDR_W-1:0]);
			check_addr("raddr", raddr, model.rptr[fifo_ctl_pkg::ADDR_W-1:0]);
			check_push(push_flags, model.push_flags);
			check_pop(pop_flags, model.pop_flags);
			if (dut_i.asserts_i.fail_count != 0) begin
				$display("A concurrent assertion on fifo_ctl failed");
				report_failure();
			end
		end
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge rclk);
			cycle_count++;
		end
		$display("Timeout after %0d cycles, the stimulus never finished", cycle_count);
		report_failure();
	end

	initial begin
		logic w;
		logic r;
		int push_bias;
		void'($urandom(SEED));
		rst_n = 1'b0;
		wen = 1'b0;
		ren = 1'b0;
		thresh = make_thresh(4, 4);
		repeat (RST_CYCLES) @(posedge rclk);
		#1;
		rst_n = 1'b1;

		// Fill past full so the last two pushes are refused
		run_cycles(1'b1, 1'b0, DEPTH + 2);
		run_cycles(1'b0, 1'b0, 1);
		expect_true(push_flags.full && push_flags.overflow,
			"fill did not end full with overflow set");

		run_cycles(1'b0, 1'b1, DEPTH + 2);
		run_cycles(1'b0, 1'b0, 1);
		expect_true(pop_flags.empty && pop_flags.underflow,
			"drain did not end empty with underflow set");
		run_cycles(1'b1, 1'b0, 1);
		run_cycles(1'b0, 1'b0, 2);
		expect_true(!push_flags.overflow, "overflow stayed set after an accepted push");

		// Extreme thresholds both ways round
		thresh = make_thresh(0, DEPTH);
		run_cycles(1'b1, 1'b0, DEPTH + 1);
		run_cycles(1'b0, 1'b1, DEPTH + 2);
		thresh = make_thresh(DEPTH, 0);
		run_cycles(1'b1, 1'b0, DEPTH + 1);
		run_cycles(1'b0, 1'b1, DEPTH + 2);

		// Bias flips every 40 cycles so the random run reaches both full and empty
		thresh = make_thresh(6, 10);
		for (int i = 0; i < N_RANDOM; i++) begin
			push_bias = ((i / 40) % 2 == 0) ? 3 : 1;
			w = (($urandom % 4) < push_bias);
			r = (($urandom % 4) < (4 - push_bias));
			run_cycles(w, r, 1);
		end
		run_cycles(1'b0, 1'b0, 2);
		@(negedge rclk);
		#1;

		if (dut_i.asserts_i.fail_count == 0) begin
			$display("NO ERRORS");
			$finish;
		end else begin
			report_failure();
		end
	end

endmodule

`default_nettype wire

// ==== sources.f ====
rtl/fifo_ctl_pkg.sv
rtl/fifo_push_ctl.sv
rtl/fifo_pop_ctl.sv
rtl/fifo_ctl.sv
tests/fifo_ctl_asserts.sv
tests/fifo_ctl_tb.sv

// ==== Bender.yml ====
package:
  name: fifo_ctl

dependencies: {}

sources:
  # Design sources in compile order
  - files:
      - rtl/fifo_ctl_pkg.sv
      - rtl/fifo_push_ctl.sv
      - rtl/fifo_pop_ctl.sv
      - rtl/fifo_ctl.sv

  # Simulation only
  - target: test
    files:
      - tests/fifo_ctl_asserts.sv
      - tests/fifo_ctl_tb.sv
